//--- srom_pkg.sv
package srom_pkg;

	// ------------------------------
	// Address and command constants
	// ------------------------------

	// Byte address width shared by flash and PSRAM
	localparam int ADDR_W = 22;

	// Flash command bytes
	localparam logic [7:0] CMD_RSTEN = 8'h66;
	localparam logic [7:0] CMD_RST   = 8'h99;
	localparam logic [7:0] CMD_READ  = 8'h03;

	// ------------------------------
	// Port bundles
	// ------------------------------

	// Host request, one byte per strobe
	typedef struct packed {
		logic        n_cs;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} host_req_t;

	// Host response, rdata only meaningful with rdata_en
	typedef struct packed {
		logic        busy;
		logic [7:0]  rdata;
		logic        rdata_en;
	} host_resp_t;

	// Flash output pins, cs active low
	typedef struct packed {
		logic        cs;
		logic        sclk;
		logic        mosi;
	} spi_pins_t;

	// One PSRAM write request
	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] address;
		logic [7:0]        wdata;
	} psram_req_t;

endpackage

//--- srom_spi_shifter.sv
`timescale 1ns/1ps

module srom_spi_shifter (
	input  logic       clk,
	input  logic       n_reset,
	input  logic       start,
	input  logic       capture,
	input  logic [7:0] tx_byte,
	output logic       done,
	output logic [7:0] rx_byte,
	output logic       sclk,
	output logic       mosi,
	input  logic       miso
);
	// Idle, 16 clock phases, final strobe
	localparam logic [4:0] ST_IDLE = 5'd0;
	localparam logic [4:0] ST_FIN  = 5'd17;

	logic [4:0] ff_state;
	logic       ff_sclk;
	logic       ff_capture;
	logic [7:0] ff_tx;
	logic [7:0] ff_rx;
	logic       w_active;

	// Odd states are low phases, even states high phases
	assign w_active = (ff_state != ST_IDLE) && (ff_state != ST_FIN);

	// ------------------------------
	// Phase counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_state <= ST_IDLE;
		end else if (ff_state == ST_IDLE) begin
			if (start) begin
				ff_state <= 5'd1;
			end
		end else if (ff_state == ST_FIN) begin
			ff_state <= ST_IDLE;
		end else begin
			ff_state <= ff_state + 5'd1;
		end
	end

	// SCLK high in states 2,4..16, low otherwise (mode 0)
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_sclk <= 1'b0;
		end else begin
			ff_sclk <= w_active ? ~ff_sclk : 1'b0;
		end
	end

	// Direction latched with the start pulse
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_capture <= 1'b0;
		end else if (ff_state == ST_IDLE && start) begin
			ff_capture <= capture;
		end
	end

	// ------------------------------
	// Data shifting
	// ------------------------------

	// MSB first, next bit appears as SCLK falls
	always_ff @(posedge clk) begin
		if (ff_state == ST_IDLE && start) begin
			ff_tx <= tx_byte;
		end else if (w_active && !ff_state[0]) begin
			ff_tx <= {ff_tx[6:0], 1'b0};
		end
	end

	// Sample at the end of each low phase
	always_ff @(posedge clk) begin
		if (ff_capture && w_active && ff_state[0]) begin
			ff_rx <= {ff_rx[6:0], miso};
		end
	end

	assign done    = (ff_state == ST_FIN);
	assign rx_byte = ff_rx;
	assign sclk    = ff_sclk;
	assign mosi    = ff_tx[7];

endmodule

//--- srom_psram_writer.sv
`timescale 1ns/1ps

module srom_psram_writer import srom_pkg::*; #(
	parameter int END_ADDRESS = 'h30_0000 - 1
) (
	input  logic       clk,
	input  logic       n_reset,
	input  logic       load,
	input  logic [7:0] data,
	input  logic       psram_busy,
	output psram_req_t psram,
	output logic       pending,
	output logic       last
);
	logic              ff_wr;
	logic [ADDR_W-1:0] ff_address;
	logic [7:0]        ff_wdata;
	logic              w_accept;

	// PSRAM takes the byte in any cycle it is not busy
	assign w_accept = ff_wr && !psram_busy;

	// ------------------------------
	// Request hold
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_wr <= 1'b0;
		end else if (load) begin
			ff_wr <= 1'b1;
		end else if (w_accept) begin
			ff_wr <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			ff_wdata <= data;
		end
	end

	// Copy address, only moves on acceptance so it doubles as request address
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_address <= '0;
		end else if (w_accept) begin
			ff_address <= ff_address + 1'b1;
		end
	end

	assign psram   = '{wr: ff_wr, address: ff_address, wdata: ff_wdata};
	assign pending = ff_wr;
	// Byte now being read lands on the final address
	assign last    = (ff_address == ADDR_W'(END_ADDRESS));

endmodule

//--- srom_sequencer.sv
`timescale 1ns/1ps

module srom_sequencer import srom_pkg::*; #(
	parameter int END_ADDRESS = 'h30_0000 - 1,
	parameter int TREADY_WAIT = 1620
) (
	input  logic       clk,
	input  logic       n_reset,
	input  host_req_t  host,
	output host_resp_t resp,
	output logic       initial_busy,
	output logic       cs,
	output logic       start,
	output logic       capture,
	output logic [7:0] tx_byte,
	input  logic       done,
	input  logic [7:0] rx_byte,
	output logic       load,
	output logic [7:0] load_data,
	input  logic       pending,
	input  logic       last
);
	localparam int TIMER_W = $clog2(TREADY_WAIT + 2);

	// Copy would never end past the counter range
	if (END_ADDRESS < 0 || END_ADDRESS >= (1 << ADDR_W)) begin : g_bad_end
		$error("END_ADDRESS outside the copy counter range");
	end

	typedef enum logic [2:0] {
		ST_SETUP, ST_XFER, ST_WAIT, ST_READY, ST_STALL, ST_DRAIN, ST_IDLE
	} state_t;

	// Byte being moved, in boot order
	typedef enum logic [2:0] {
		STEP_RSTEN, STEP_RST, STEP_READ, STEP_ADDR0,
		STEP_ADDR1, STEP_ADDR2, STEP_DATA, STEP_HOST
	} step_t;

	state_t             ff_state;
	step_t              ff_step;
	logic [TIMER_W-1:0] ff_timer;
	logic               ff_cs;
	logic               ff_busy;
	logic               ff_rdata_en;
	logic               ff_host_rd;
	logic [7:0]         ff_host_wdata;
	logic               w_accept;
	logic               w_host_end;

	assign initial_busy = (ff_step != STEP_HOST);
	// Strobe taken only from idle, wr wins over rd
	assign w_accept     = (ff_state == ST_IDLE) && !ff_busy && !initial_busy &&
	                      (host.wr || host.rd);
	assign w_host_end   = (ff_state == ST_WAIT) && (ff_step == STEP_HOST);

	// ------------------------------
	// Main FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_state <= ST_SETUP;
			ff_step  <= STEP_RSTEN;
			ff_timer <= '0;
		end else begin
			case (ff_state)
				ST_SETUP: begin
					ff_state <= ST_XFER;
				end
				ST_XFER: begin
					if (done) begin
						ff_state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					case (ff_step)
						STEP_RST: begin
							ff_state <= ST_READY;
							ff_step  <= STEP_READ;
							ff_timer <= TIMER_W'(TREADY_WAIT);
						end
						// byte just loaded, stall or finish
						STEP_DATA: begin
							ff_state <= last ? ST_DRAIN : ST_STALL;
						end
						STEP_HOST: begin
							ff_state <= ST_IDLE;
						end
						default: begin
							ff_state <= ST_SETUP;
							ff_step  <= step_t'(ff_step + 3'd1);
						end
					endcase
				end
				// Flash reset recovery
				ST_READY: begin
					if (ff_timer == '0) begin
						ff_state <= ST_SETUP;
					end else begin
						ff_timer <= ff_timer - 1'b1;
					end
				end
				// Back-pressure before the next data byte
				ST_STALL: begin
					if (!pending) begin
						ff_state <= ST_SETUP;
					end
				end
				// Final write must land before boot ends
				ST_DRAIN: begin
					if (!pending) begin
						ff_state <= ST_IDLE;
						ff_step  <= STEP_HOST;
					end
				end
				ST_IDLE: begin
					if (w_accept) begin
						ff_state <= ST_SETUP;
					end
				end
				default: begin
					ff_state <= ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------
	// Chip select
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_cs <= 1'b1;
		end else if (ff_state == ST_IDLE) begin
			ff_cs <= host.n_cs;
		end else if (ff_state == ST_XFER && done &&
		             (ff_step == STEP_RSTEN || ff_step == STEP_RST)) begin
			// One high cycle closes each reset command
			ff_cs <= 1'b1;
		end else if (ff_step != STEP_HOST &&
		             (ff_state == ST_SETUP || ff_state == ST_WAIT)) begin
			ff_cs <= 1'b0;
		end
	end

	// ------------------------------
	// Host side
	// ------------------------------
	always_ff @(posedge clk) begin
		if (w_accept) begin
			ff_host_rd    <= !host.wr;
			ff_host_wdata <= host.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_busy     <= 1'b0;
			ff_rdata_en <= 1'b0;
		end else begin
			if (w_accept) begin
				ff_busy <= 1'b1;
			end else if (w_host_end) begin
				ff_busy <= 1'b0;
			end
			ff_rdata_en <= w_host_end && ff_host_rd;
		end
	end

	// Shifter still holds the received byte here
	assign resp = '{busy: ff_busy, rdata: ff_rdata_en ? rx_byte : 8'h00,
	                rdata_en: ff_rdata_en};

	// ------------------------------
	// Shifter and writer controls
	// ------------------------------
	always_comb begin
		case (ff_step)
			STEP_RSTEN: tx_byte = CMD_RSTEN;
			STEP_RST:   tx_byte = CMD_RST;
			STEP_READ:  tx_byte = CMD_READ;
			STEP_HOST:  tx_byte = ff_host_wdata;
			// address bytes are zero, data phase sends filler
			default:    tx_byte = 8'h00;
		endcase
	end

	assign start     = (ff_state == ST_SETUP);
	assign capture   = (ff_step == STEP_DATA) || (ff_step == STEP_HOST && ff_host_rd);
	assign cs        = ff_cs;
	assign load      = (ff_state == ST_WAIT) && (ff_step == STEP_DATA);
	assign load_data = rx_byte;

endmodule

//--- srom_top.sv
`timescale 1ns/1ps

module srom_top import srom_pkg::*; #(
	parameter int END_ADDRESS = 'h30_0000 - 1,
	parameter int TREADY_WAIT = 1620
) (
	input  logic       clk,
	input  logic       n_reset,
	input  host_req_t  host,
	output host_resp_t resp,
	output logic       initial_busy,
	output spi_pins_t  flash,
	input  logic       miso,
	output psram_req_t psram,
	input  logic       psram_busy
);
	logic       w_cs;
	logic       w_sclk;
	logic       w_mosi;
	logic       w_start;
	logic       w_capture;
	logic [7:0] w_tx_byte;
	logic       w_done;
	logic [7:0] w_rx_byte;
	logic       w_load;
	logic [7:0] w_load_data;
	logic       w_pending;
	logic       w_last;

	// ------------------------------
	// Boot and host control
	// ------------------------------
	srom_sequencer #(
		.END_ADDRESS (END_ADDRESS),
		.TREADY_WAIT (TREADY_WAIT)
	) i_sequencer (
		.clk          (clk),
		.n_reset      (n_reset),
		.host         (host),
		.resp         (resp),
		.initial_busy (initial_busy),
		.cs           (w_cs),
		.start        (w_start),
		.capture      (w_capture),
		.tx_byte      (w_tx_byte),
		.done         (w_done),
		.rx_byte      (w_rx_byte),
		.load         (w_load),
		.load_data    (w_load_data),
		.pending      (w_pending),
		.last         (w_last)
	);

	// Serial byte engine
	srom_spi_shifter i_shifter (
		.clk     (clk),
		.n_reset (n_reset),
		.start   (w_start),
		.capture (w_capture),
		.tx_byte (w_tx_byte),
		.done    (w_done),
		.rx_byte (w_rx_byte),
		.sclk    (w_sclk),
		.mosi    (w_mosi),
		.miso    (miso)
	);

	// PSRAM copy port
	srom_psram_writer #(
		.END_ADDRESS (END_ADDRESS)
	) i_writer (
		.clk        (clk),
		.n_reset    (n_reset),
		.load       (w_load),
		.data       (w_load_data),
		.psram_busy (psram_busy),
		.psram      (psram),
		.pending    (w_pending),
		.last       (w_last)
	);

	assign flash = '{cs: w_cs, sclk: w_sclk, mosi: w_mosi};

endmodule

//--- srom_assert.sv
`timescale 1ns/1ps

module srom_assert import srom_pkg::*; (
	input logic       clk,
	input logic       n_reset,
	input host_resp_t resp,
	input spi_pins_t  flash,
	input psram_req_t psram,
	input logic       psram_busy
);
	// ------------------------------
	// PSRAM port
	// ------------------------------
	// Held request keeps address and data
	a_psram_hold: assert property (@(posedge clk) disable iff (!n_reset)
		psram.wr && psram_busy |=>
			psram.wr && $stable(psram.address) && $stable(psram.wdata))
		else $error("PSRAM request changed while busy");

	// Host read data only inside the pulse
	a_rdata_zero: assert property (@(posedge clk) disable iff (!n_reset)
		!resp.rdata_en |-> resp.rdata == 8'h00)
		else $error("rdata nonzero without rdata_en");

	// No clock to a deselected flash
	a_sclk_idle: assert property (@(posedge clk) disable iff (!n_reset)
		flash.cs |-> !flash.sclk)
		else $error("sclk high while cs is high");

endmodule

bind srom_top srom_assert i_srom_assert (
	.clk        (clk),
	.n_reset    (n_reset),
	.resp       (resp),
	.flash      (flash),
	.psram      (psram),
	.psram_busy (psram_busy)
);

//--- tb_srom_flash_model.sv
`timescale 1ns/1ps

module tb_srom_flash_model import srom_pkg::*; (
	input  logic cs,
	input  logic sclk,
	input  logic mosi,
	output logic miso,
	output int   byte_count,
	output int   reset_pairs,
	output logic read_early
);
	logic [7:0]  in_shift;
	int          in_bits;
	int          frame_bytes;
	logic [7:0]  cmd;
	logic [23:0] addr;
	logic        streaming;
	logic        rsten_armed;
	logic [7:0]  out_shift;
	int          out_bits;

	// Image content, low byte of a*7+3
	function automatic logic [7:0] image_byte(input logic [23:0] a);
		logic [31:0] v;
		v = a * 7 + 3;
		return v[7:0];
	endfunction

	initial begin
		miso        = 1'b0;
		byte_count  = 0;
		reset_pairs = 0;
		read_early  = 1'b0;
		in_bits     = 0;
		frame_bytes = 0;
		streaming   = 1'b0;
		rsten_armed = 1'b0;
		out_bits    = 0;
		addr        = '0;
	end

	// Deselect ends the frame
	always @(posedge cs) begin
		in_bits     = 0;
		frame_bytes = 0;
		streaming   = 1'b0;
		out_bits    = 0;
	end

	// ------------------------------
	// Command and address input
	// ------------------------------
	always @(posedge sclk) begin
		if (cs === 1'b0) begin
			in_shift = {in_shift[6:0], mosi};
			in_bits++;
			if (in_bits == 8) begin
				in_bits = 0;
				byte_count++;
				if (frame_bytes == 0) begin
					cmd = in_shift;
					if (cmd == CMD_RSTEN) begin
						rsten_armed = 1'b1;
					end else begin
						// Reset only counts right after a reset-enable frame
						if (cmd == CMD_RST && rsten_armed) begin
							reset_pairs++;
						end
						if (cmd == CMD_READ && reset_pairs == 0) begin
							read_early = 1'b1;
						end
						rsten_armed = 1'b0;
					end
				end else if (cmd == CMD_READ && frame_bytes <= 3) begin
					addr = {addr[15:0], in_shift};
					if (frame_bytes == 3) begin
						streaming = 1'b1;
						out_shift = image_byte(addr);
						out_bits  = 0;
					end
				end
				frame_bytes++;
			end
		end
	end

	// Read data out, next bit on each falling edge
	always @(negedge sclk) begin
		if (cs === 1'b0 && streaming) begin
			miso <= out_shift[7];
			out_shift = {out_shift[6:0], 1'b0};
			out_bits++;
			if (out_bits == 8) begin
				addr      = addr + 1'b1;
				out_shift = image_byte(addr);
				out_bits  = 0;
			end
		end
	end

endmodule

//--- tb_srom.sv
`timescale 1ns/1ps

module tb_srom import srom_pkg::*; ();

	localparam int END_ADDRESS = 63;
	localparam int TREADY_WAIT = 20;
	localparam int N_BYTES     = END_ADDRESS + 1;

	logic       clk;
	logic       n_reset;
	host_req_t  host_req;
	host_resp_t resp;
	logic       initial_busy;
	spi_pins_t  flash;
	logic       miso;
	psram_req_t psram;
	logic       psram_busy;

	// Flash model counters
	int         flash_bytes;
	int         reset_pairs;
	logic       read_early;

	// PSRAM model state
	logic [7:0] psram_mem [0:N_BYTES-1];
	int         write_count [0:N_BYTES-1];
	int         stray_writes;
	int         hold_left;
	logic       holding;
	int unsigned seed;

	// Stimulus, one {op, value, expected} word per entry
	logic [23:0] stim [0:63];
	int          n_ops;

	int          errors = 0;
	int          checks = 0;
	int          rd_pulses = 0;
	logic [7:0]  last_rdata;
	int          boot_busy_seen = 0;
	int          boot_cycles;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	srom_top #(
		.END_ADDRESS (END_ADDRESS),
		.TREADY_WAIT (TREADY_WAIT)
	) i_srom_top (
		.clk          (clk),
		.n_reset      (n_reset),
		.host         (host_req),
		.resp         (resp),
		.initial_busy (initial_busy),
		.flash        (flash),
		.miso         (miso),
		.psram        (psram),
		.psram_busy   (psram_busy)
	);

	tb_srom_flash_model i_flash_model (
		.cs          (flash.cs),
		.sclk        (flash.sclk),
		.mosi        (flash.mosi),
		.miso        (miso),
		.byte_count  (flash_bytes),
		.reset_pairs (reset_pairs),
		.read_early  (read_early)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	// Expected flash content, low byte of a*7+3
	function automatic logic [7:0] image_byte(input int a);
		int v;
		v = a * 7 + 3;
		return v[7:0];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
	                             input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic set_chip_select(input logic level, input string name);
		@(posedge clk);
		host_req.n_cs <= level;
		@(posedge clk);
		@(negedge clk);
		compare_value({name, " cs level"}, level, flash.cs);
	endtask

	// One byte over the host port, plus a second strobe that must be ignored
	task automatic host_transfer(input logic is_read, input logic [7:0] tx,
	                             input logic [7:0] expected, input string name);
		int bytes_before;
		int pulses_before;
		bytes_before  = flash_bytes;
		pulses_before = rd_pulses;
		@(posedge clk);
		host_req.wr    <= !is_read;
		host_req.rd    <= is_read;
		host_req.wdata <= tx;
		@(posedge clk);
		host_req.wr <= 1'b0;
		host_req.rd <= 1'b0;
		@(negedge clk);
		compare_value({name, " busy rise"}, 1, resp.busy);
		// Strobe again while busy
		@(posedge clk);
		host_req.wr <= !is_read;
		host_req.rd <= is_read;
		@(posedge clk);
		host_req.wr <= 1'b0;
		host_req.rd <= 1'b0;
		@(negedge clk);
		// Watchdog covers a stuck busy
		while (resp.busy) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		compare_value({name, " bytes moved"}, 1, flash_bytes - bytes_before);
		compare_value({name, " rdata_en pulses"}, is_read, rd_pulses - pulses_before);
		if (is_read) begin
			compare_value({name, " read data"}, expected, last_rdata);
		end
	endtask

	// ------------------------------
	// PSRAM model
	// ------------------------------
	// Busy held 0..3 extra cycles against each new request
	initial begin
		seed         = $urandom(4);
		psram_busy   = 1'b1;
		stray_writes = 0;
		holding      = 1'b0;
		hold_left    = 0;
		for (int i = 0; i < N_BYTES; i++) begin
			write_count[i] = 0;
		end
		forever begin
			@(posedge clk);
			if (!n_reset) begin
				psram_busy <= 1'b1;
				holding = 1'b0;
			end else if (psram.wr && !psram_busy) begin
				if (psram.address < N_BYTES) begin
					psram_mem[psram.address] = psram.wdata;
					write_count[psram.address]++;
				end else begin
					stray_writes++;
				end
				psram_busy <= 1'b1;
				holding = 1'b0;
			end else if (psram.wr) begin
				if (!holding) begin
					holding   = 1'b1;
					hold_left = $urandom % 4;
				end
				if (hold_left == 0) begin
					psram_busy <= 1'b0;
				end else begin
					hold_left--;
				end
			end
		end
	end

	// Output monitors, sampled mid-cycle
	always @(negedge clk) begin
		if (resp.rdata_en) begin
			rd_pulses++;
			last_rdata = resp.rdata;
		end
		if (initial_busy === 1'b1 && resp.busy) begin
			boot_busy_seen++;
		end
	end

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		n_reset  = 1'b0;
		host_req = '{n_cs: 1'b1, rd: 1'b0, wr: 1'b0, wdata: 8'h00};
		for (int i = 0; i < 64; i++) begin
			stim[i] = 24'hff_ffff;
		end
		$readmemh("srom_stimulus.txt", stim);
		n_ops = 0;
		while (n_ops < 64 && stim[n_ops][23:16] != 8'hff) begin
			n_ops++;
		end
		cycle_limit = 4 * ((N_BYTES * 22 + 200) + 30 * n_ops);
		if (n_ops == 0) begin
			errors++;
			$display("Stimulus file is missing or holds no operations");
		end

		// Reset values, checked inside the reset window
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare_value("reset cs", 1, flash.cs);
		compare_value("reset sclk", 0, flash.sclk);
		compare_value("reset psram wr", 0, psram.wr);
		compare_value("reset busy", 0, resp.busy);
		compare_value("reset rdata_en", 0, resp.rdata_en);
		compare_value("reset initial_busy", 1, initial_busy);
		@(posedge clk);
		n_reset <= 1'b1;

		// Boot with stray host strobes early on
		boot_cycles = 0;
		while (initial_busy) begin
			@(posedge clk);
			host_req.wr    <= (boot_cycles % 60 == 10) && (boot_cycles < 600);
			host_req.rd    <= (boot_cycles % 60 == 40) && (boot_cycles < 600);
			host_req.wdata <= 8'h5a;
			boot_cycles++;
		end
		@(negedge clk);

		compare_value("boot reset pairs", 1, reset_pairs);
		compare_value("boot read before reset", 0, read_early);
		compare_value("boot flash bytes", 2 + 4 + N_BYTES, flash_bytes);
		compare_value("boot busy cycles", 0, boot_busy_seen);
		compare_value("boot stray writes", 0, stray_writes);
		for (int a = 0; a < N_BYTES; a++) begin
			compare_value($sformatf("boot write count %0d", a), 1, write_count[a]);
			compare_value($sformatf("boot psram data %0d", a), image_byte(a), psram_mem[a]);
		end

		// Host phase from the stimulus file
		for (int i = 0; i < n_ops; i++) begin
			case (stim[i][23:16])
				8'h00: set_chip_select(stim[i][8], $sformatf("stimulus %0d", i));
				8'h01: host_transfer(1'b0, stim[i][15:8], 8'h00, $sformatf("stimulus %0d", i));
				8'h02: host_transfer(1'b1, stim[i][15:8], stim[i][7:0],
				                     $sformatf("stimulus %0d", i));
				default: begin
					errors++;
					$display("Stimulus entry %0d has an unknown operation code", i);
				end
			endcase
		end

		repeat (4) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- srom_stimulus.txt
// Host phase, one entry per line: op_value_expected in hex
// op 00 sets n_cs to value, 01 writes value, 02 reads (sends value) and expects the last byte
00_00_00  // select
01_03_00  // read command, address 0
01_00_00
01_00_00
01_00_00
02_00_03
02_00_0a
02_00_11
02_00_18
02_00_1f
00_01_00  // deselect, new frame at 0x10
00_00_00
01_03_00
01_00_00
01_00_00
01_10_00
02_ff_73
02_ff_7a
02_ff_81
02_ff_88
00_01_00  // deselect, new frame at 0x25
00_00_00
01_03_00
01_00_00
01_00_00
01_25_00
02_a5_06
02_a5_0d
00_01_00

//--- compile.f
srom_pkg.sv
srom_spi_shifter.sv
srom_psram_writer.sv
srom_sequencer.sv
srom_top.sv
srom_assert.sv
tb_srom_flash_model.sv
tb_srom.sv
